// File: verilog/pe_feed_params.svh
// frame geometry, padding border and credit depth of the PE feed stage
`ifndef PE_FEED_PARAMS_SVH
`define PE_FEED_PARAMS_SVH

// input frame
`define IMG_ROWS 24
`define IMG_COLS 32

// padded output column, one pixel border on every side
`define PAD_ROWS 26
`define PAD_COLS 34

`define FRAME_PIX 768 // pixels per bank

`define CREDIT_MAX 4 // receiver column slots

`endif

// File: verilog/pix_pkg.sv
// pixel, padded column and address types of the PE feed stage
`include "pe_feed_params.svh"

package pix_pkg;

  // one camera pixel
  typedef logic [7:0] pixel_t;

  typedef logic [9:0] pix_addr_t; // address inside one bank

  // element 0 is the column top and lands in the msb byte
  typedef pixel_t [0:`PAD_ROWS-1] pad_col_t;

  typedef logic [5:0] col_idx_t; // padded column 0..33

endpackage

// File: verilog/ctrl_pkg.sv
// FSM state types for the raster writer and the column assembler
package ctrl_pkg;

  typedef enum logic {
    W_FILL, // accepting pixels
    W_WAIT  // next bank still full
  } wr_state_t;

  typedef enum logic [2:0] {
    A_IDLE,   // wait for a full bank
    A_PADCOL, // all-pad column
    A_READ,   // fetch one data column
    A_LAST,   // release bank
    A_HOLD    // offer column downstream
  } asm_state_t;

endpackage

// File: verilog/frame_bank_if.sv
// bank bus between the ping-pong frame buffer, its writer and its column reader
`timescale 1ns/1ns

interface frame_bank_if
  import pix_pkg::*;
();

  // write side
  logic      wr_en;
  logic      wr_bank;
  pix_addr_t wr_addr;
  pixel_t    wr_data;

  logic [1:0] bank_full; // one flag per bank

  // read side
  logic      rd_bank;
  pix_addr_t rd_addr;
  logic      rd_en;
  logic      rel;      // bank release pulse
  pixel_t    rd_data;  // valid one cycle after rd_en

  modport writer (output wr_en, wr_bank, wr_addr, wr_data, input bank_full);

  modport reader (output rd_bank, rd_addr, rd_en, rel, input bank_full, rd_data);

  modport buffer (input wr_en, wr_bank, wr_addr, wr_data, rd_bank, rd_addr, rd_en, rel,
                  output bank_full, rd_data);

endinterface

// File: verilog/pixel_writer.sv
// raster pixel writer, fills the banks in turn and back-pressures the source
`timescale 1ns/1ns
`include "pe_feed_params.svh"

module pixel_writer
  import pix_pkg::*;
  import ctrl_pkg::*;
(
  input  logic         PEclk,
  input  logic         rst_n,
  input  pixel_t       i_pix,
  input  logic         i_pix_vld,
  output logic         o_pix_rdy,
  frame_bank_if.writer bank
);

  wr_state_t state;
  pix_addr_t addr_q;
  logic      bank_q;
  logic      accept;
  logic      last_pix;

  assign o_pix_rdy = (state == W_FILL);
  assign accept    = i_pix_vld && o_pix_rdy;
  assign last_pix  = (addr_q == pix_addr_t'(`FRAME_PIX - 1));

  // write straight through, buffer sees wr_en in the accept cycle
  assign bank.wr_en   = accept;
  assign bank.wr_bank = bank_q;
  assign bank.wr_addr = addr_q;
  assign bank.wr_data = i_pix;

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= W_FILL;
      addr_q <= '0;
      bank_q <= 1'b0;
    end else begin
      unique case (state)
        W_FILL: begin
          if (accept) begin
            if (last_pix) begin
              addr_q <= '0;
              bank_q <= ~bank_q; // switch to the other bank
              state  <= W_WAIT;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        W_WAIT: begin
          if (!bank.bank_full[bank_q]) state <= W_FILL; // reader freed it
        end
        default: state <= W_FILL;
      endcase
    end
  end

endmodule

// File: verilog/pingpong_frame_buf.sv
// two-bank ping-pong frame store with per-bank full flags and a registered read
`timescale 1ns/1ns
`include "pe_feed_params.svh"

module pingpong_frame_buf
  import pix_pkg::*;
(
  input  logic         PEclk,
  input  logic         rst_n,
  frame_bank_if.buffer bank
);

  pixel_t mem [2][`FRAME_PIX];
  logic   last_wr;

  assign last_wr = bank.wr_en && (bank.wr_addr == pix_addr_t'(`FRAME_PIX - 1));

  always_ff @(posedge PEclk) begin
    if (bank.wr_en) mem[bank.wr_bank][bank.wr_addr] <= bank.wr_data;
  end

  // one cycle read latency
  always_ff @(posedge PEclk) begin
    if (bank.rd_en) bank.rd_data <= mem[bank.rd_bank][bank.rd_addr];
  end

  // full flags, set by the last raster write, cleared by rel
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      bank.bank_full <= 2'b00;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (last_wr && (bank.wr_bank == b[0])) begin
          bank.bank_full[b] <= 1'b1;
        end else if (bank.rel && (bank.rd_bank == b[0])) begin
          bank.bank_full[b] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verilog/column_assembler.sv
// column assembler, reads a full bank column-wise and builds padded columns
`timescale 1ns/1ns
`include "pe_feed_params.svh"

module column_assembler
  import pix_pkg::*;
  import ctrl_pkg::*;
(
  input  logic         PEclk,
  input  logic         rst_n,
  input  pixel_t       i_pad,
  frame_bank_if.reader bank,
  output logic         o_col_vld,
  output pad_col_t     o_col_data,
  output logic         o_col_last,
  input  logic         i_hold_free
);

  localparam col_idx_t LAST_COL = col_idx_t'(`PAD_COLS - 1);
  localparam logic [4:0] ROWS = 5'(`IMG_ROWS);

  asm_state_t state;
  col_idx_t   col;
  col_idx_t   col_m1;   // source column of the frame
  logic [4:0] cnt;      // read issue / capture step
  logic       cur_bank;
  logic       start;
  pixel_t     pad_q;
  pad_col_t   col_buf;

  assign col_m1 = col - col_idx_t'(1);
  assign start  = (state == A_IDLE) && bank.bank_full[cur_bank];

  assign bank.rd_bank = cur_bank;
  assign bank.rd_en   = (state == A_READ) && (cnt < ROWS);
  assign bank.rd_addr = pix_addr_t'(cnt * `IMG_COLS + col_m1); // row cnt, col c-1
  assign bank.rel     = (state == A_LAST);

  assign o_col_vld  = (state == A_HOLD);
  assign o_col_data = col_buf;
  assign o_col_last = (state == A_HOLD) && (col == LAST_COL);

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= A_IDLE;
      col      <= '0;
      cnt      <= '0;
      cur_bank <= 1'b0;
    end else begin
      unique case (state)
        A_IDLE: begin
          if (start) begin
            col   <= '0;
            state <= A_PADCOL;
          end
        end
        A_PADCOL: state <= A_HOLD;
        A_READ: begin
          cnt <= cnt + 1'b1;
          if (cnt == ROWS) state <= A_HOLD; // last capture
        end
        A_HOLD: begin
          if (i_hold_free) begin
            if (col == LAST_COL) begin
              state <= A_LAST;
            end else begin
              col   <= col + 1'b1;
              cnt   <= '0;
              state <= (col == LAST_COL - 1'b1) ? A_PADCOL : A_READ;
            end
          end
        end
        A_LAST: begin
          cur_bank <= ~cur_bank; // next frame in the other bank
          state    <= A_IDLE;
        end
        default: state <= A_IDLE;
      endcase
    end
  end

  // column payload
  always_ff @(posedge PEclk) begin
    if (start) pad_q <= i_pad; // one pad value per frame
    if (state == A_PADCOL) col_buf <= {`PAD_ROWS{pad_q}};
    if (state == A_READ) begin
      if (cnt == '0) begin
        col_buf[0]           <= pad_q; // top border
        col_buf[`PAD_ROWS-1] <= pad_q; // bottom border
      end else begin
        col_buf[cnt] <= bank.rd_data; // row cnt-1 lands in element cnt
      end
    end
  end

endmodule

// File: verilog/credit_tx.sv
// credit-limited column sender with a one-column holding register
`timescale 1ns/1ns
`include "pe_feed_params.svh"

module credit_tx
  import pix_pkg::*;
(
  input  logic     PEclk,
  input  logic     rst_n,
  input  logic     i_col_vld,
  input  pad_col_t i_col_data,
  input  logic     i_col_last,
  output logic     o_hold_free,
  output logic     o_col_vld,
  output pad_col_t o_col_data,
  output logic     o_col_last,
  input  logic     i_credit_rtn
);

  localparam int CW = $clog2(`CREDIT_MAX + 1);

  logic          hold_full;
  pad_col_t      hold_data;
  logic          hold_last;
  logic [CW-1:0] credits;
  logic          send;
  logic          load;

  assign send        = hold_full && (credits != '0);
  assign o_hold_free = !hold_full || send; // refill while sending
  assign load        = i_col_vld && o_hold_free;

  assign o_col_vld  = send;
  assign o_col_data = hold_data;
  assign o_col_last = send && hold_last;

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      hold_full <= 1'b0;
      credits   <= CW'(`CREDIT_MAX);
    end else begin
      if (load) hold_full <= 1'b1;
      else if (send) hold_full <= 1'b0;
      unique case ({send, i_credit_rtn})
        2'b10: credits <= credits - 1'b1;
        2'b01: if (credits != CW'(`CREDIT_MAX)) credits <= credits + 1'b1;
        default: ; // both or neither, count unchanged
      endcase
    end
  end

  always_ff @(posedge PEclk) begin
    if (load) begin
      hold_data <= i_col_data;
      hold_last <= i_col_last;
    end
  end

endmodule

// File: verilog/pe_feed_top.sv
// PE feed stage top, raster pixels in, padded columns out under credits
`timescale 1ns/1ns
`include "pe_feed_params.svh"

module pe_feed_top
  import pix_pkg::*;
(
  input  logic                     PEclk,
  input  logic                     rst_n,
  input  pixel_t                   i_pix,
  input  logic                     i_pix_vld,
  output logic                     o_pix_rdy,
  input  pixel_t                   i_pad,
  output logic                     o_col_vld,
  output logic [`PAD_ROWS*8-1:0]   o_col_data,
  output logic                     o_col_last,
  input  logic                     i_credit_rtn
);

  frame_bank_if bank_bus ();

  logic     col_vld;   // assembler to sender
  logic     col_last;
  logic     hold_free;
  pad_col_t asm_col;
  pad_col_t tx_col;

  pixel_writer u_writer (
    .PEclk     (PEclk),
    .rst_n     (rst_n),
    .i_pix     (i_pix),
    .i_pix_vld (i_pix_vld),
    .o_pix_rdy (o_pix_rdy),
    .bank      (bank_bus)
  );

  pingpong_frame_buf u_buf (
    .PEclk (PEclk),
    .rst_n (rst_n),
    .bank  (bank_bus)
  );

  column_assembler u_asm (
    .PEclk       (PEclk),
    .rst_n       (rst_n),
    .i_pad       (i_pad),
    .bank        (bank_bus),
    .o_col_vld   (col_vld),
    .o_col_data  (asm_col),
    .o_col_last  (col_last),
    .i_hold_free (hold_free)
  );

  credit_tx u_tx (
    .PEclk        (PEclk),
    .rst_n        (rst_n),
    .i_col_vld    (col_vld),
    .i_col_data   (asm_col),
    .i_col_last   (col_last),
    .o_hold_free  (hold_free),
    .o_col_vld    (o_col_vld),
    .o_col_data   (tx_col),
    .o_col_last   (o_col_last),
    .i_credit_rtn (i_credit_rtn)
  );

  assign o_col_data = tx_col; // element 0 in the msb byte

endmodule

// File: sim/tb_pe_feed.sv
// testbench for the PE feed stage that drives raster frames and checks every padded column
`timescale 1ns/1ns
`include "pe_feed_params.svh"

module tb_pe_feed
  import pix_pkg::*;
();

  localparam int MAX_FRAMES = 8;
  localparam int MAX_SPOTS  = 32;
  localparam int PIX_WAIT   = 6000;  // cycles a pixel may sit in back-pressure
  localparam int STALL_WAIT = 4000;
  localparam int RUN_WAIT   = 20000;
  localparam col_idx_t LAST_COL = col_idx_t'(`PAD_COLS - 1);

  logic                   PEclk;
  logic                   rst_n;
  pixel_t                 i_pix;
  logic                   i_pix_vld;
  logic                   o_pix_rdy;
  pixel_t                 i_pad;
  logic                   o_col_vld;
  logic [`PAD_ROWS*8-1:0] o_col_data;
  logic                   o_col_last;
  logic                   i_credit_rtn;

  int f_pad [MAX_FRAMES];
  int f_base [MAX_FRAMES];
  int f_step [MAX_FRAMES];
  int f_stall [MAX_FRAMES];
  int n_frames;
  int s_frame [MAX_SPOTS];
  int s_col [MAX_SPOTS];
  int s_elem [MAX_SPOTS];
  int s_val [MAX_SPOTS];
  int n_spots;

  int       frames_out;
  col_idx_t col;          // padded column of the next beat
  int       outstanding;  // beats not yet credited back
  int       rtn_delay;
  logic     stall_req;
  logic     rdy_fell;
  int       low_run;
  int       hold_cnt;
  int       stall_cycles;

  pe_feed_top i_dut (
    .PEclk        (PEclk),
    .rst_n        (rst_n),
    .i_pix        (i_pix),
    .i_pix_vld    (i_pix_vld),
    .o_pix_rdy    (o_pix_rdy),
    .i_pad        (i_pad),
    .o_col_vld    (o_col_vld),
    .o_col_data   (o_col_data),
    .o_col_last   (o_col_last),
    .i_credit_rtn (i_credit_rtn)
  );

  always #20 PEclk = ~PEclk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pix(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) abort_run($sformatf("ERROR %s got 0x%02h expected 0x%02h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_col_idx(input string name, input col_idx_t got, input col_idx_t exp);
    if (got !== exp) abort_run($sformatf("ERROR %s got 0x%02h expected 0x%02h", name, got, exp));
  endtask

  // pixel n of frame f in raster order
  function automatic pixel_t raster_pixel(input int f, input int n);
    return pixel_t'(f_base[f] + f_step[f] * n);
  endfunction

  function automatic pixel_t expected_elem(input int f, input int c, input int e);
    if (c == 0 || c == `PAD_COLS - 1 || e == 0 || e == `PAD_ROWS - 1) return pixel_t'(f_pad[f]);
    return raster_pixel(f, (e - 1) * `IMG_COLS + (c - 1)); // row e-1, column c-1
  endfunction

  task automatic load_stimulus();
    int    fd;
    string line;
    int    a;
    int    b;
    int    c;
    int    d;
    fd = $fopen("sim/pe_feed_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open sim/pe_feed_stimulus.txt");
    n_frames = 0;
    n_spots  = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) == "F" && n_frames < MAX_FRAMES) begin
        if ($sscanf(line, "F %h %h %h %d", a, b, c, d) != 4) begin
          abort_run("bad frame line in stimulus");
        end
        f_pad[n_frames]   = a;
        f_base[n_frames]  = b;
        f_step[n_frames]  = c;
        f_stall[n_frames] = d;
        n_frames++;
      end else if (line.len() > 0 && line.getc(0) == "C" && n_spots < MAX_SPOTS) begin
        if ($sscanf(line, "C %d %d %d %h", a, b, c, d) != 4) begin
          abort_run("bad check line in stimulus");
        end
        s_frame[n_spots] = a;
        s_col[n_spots]   = b;
        s_elem[n_spots]  = c;
        s_val[n_spots]   = d;
        n_spots++;
      end
    end
    $fclose(fd);
    if (n_frames == 0) abort_run("no frames found in stimulus");
  endtask

  task automatic drive_frame(input int f);
    int n;
    int waited;
    if (f_stall[f] != 0) stall_req = 1'b1; // receiver withholds credits
    n = 0;
    while (n < `FRAME_PIX) begin
      @(negedge PEclk);
      if ($urandom_range(3) == 0) begin
        i_pix_vld = 1'b0; // idle gap
      end else begin
        i_pix     = raster_pixel(f, n);
        i_pix_vld = 1'b1;
        waited    = 0;
        while (!o_pix_rdy) begin
          waited++;
          if (waited > PIX_WAIT) abort_run("timeout waiting for o_pix_rdy to accept a pixel");
          @(negedge PEclk);
        end
        n++;
      end
    end
  endtask

  // checks one output beat on the falling edge
  task automatic check_beat();
    pixel_t got;
    check_flag("o_col_vld credit available", outstanding < `CREDIT_MAX, 1'b1);
    outstanding++;
    if (frames_out >= n_frames) abort_run("column seen after the last frame");
    for (int e = 0; e < `PAD_ROWS; e++) begin
      got = o_col_data[(`PAD_ROWS - 1 - e) * 8 +: 8];
      check_pix($sformatf("o_col_data f%0d c%0d e%0d", frames_out, col, e), got,
                expected_elem(frames_out, col, e));
    end
    for (int s = 0; s < n_spots; s++) begin
      if (s_frame[s] == frames_out && s_col[s] == col) begin
        got = o_col_data[(`PAD_ROWS - 1 - s_elem[s]) * 8 +: 8];
        check_pix($sformatf("o_col_data spot %0d", s), got, pixel_t'(s_val[s]));
        check_pix($sformatf("stimulus spot %0d", s), pixel_t'(s_val[s]),
                  expected_elem(s_frame[s], s_col[s], s_elem[s]));
      end
    end
    if (col == LAST_COL) check_flag("o_col_last", o_col_last, 1'b1);
    // next frame cannot start before column 32 of this one has left
    if (col >= LAST_COL - 1'b1 && frames_out + 1 < n_frames) begin
      i_pad = pixel_t'(f_pad[frames_out + 1]);
    end
    if (o_col_last) begin
      check_col_idx("column count", col, LAST_COL);
      col = '0;
      frames_out++;
    end else begin
      col = col + 1'b1;
    end
  endtask

  task automatic return_credit();
    i_credit_rtn = 1'b0;
    if (stall_req) begin
      stall_cycles++;
      if (stall_cycles > STALL_WAIT) begin
        abort_run("timeout waiting for o_pix_rdy to fall in a stall frame");
      end
      low_run = o_pix_rdy ? 0 : low_run + 1;
      if (low_run >= 16) rdy_fell = 1'b1; // both banks buffered
      if (rdy_fell) hold_cnt++;
      if (hold_cnt >= 200) begin
        check_flag("o_col_vld beats at credit limit", outstanding == `CREDIT_MAX, 1'b1);
        stall_req    = 1'b0;
        rdy_fell     = 1'b0;
        hold_cnt     = 0;
        low_run      = 0;
        stall_cycles = 0;
      end
    end else if (outstanding > 0) begin
      if (rtn_delay == 0) begin
        i_credit_rtn = 1'b1;
        outstanding--;
        rtn_delay = $urandom_range(7);
      end else begin
        rtn_delay--;
      end
    end
  endtask

  // receiver model
  always @(negedge PEclk) begin
    if (rst_n) begin
      if (o_col_vld) check_beat();
      return_credit();
    end
  end

  initial begin
    int waited;
    void'($urandom(43));
    PEclk        = 1'b0;
    rst_n        = 1'b0;
    i_pix        = '0;
    i_pix_vld    = 1'b0;
    i_pad        = '0;
    i_credit_rtn = 1'b0;
    frames_out   = 0;
    col          = '0;
    outstanding  = 0;
    rtn_delay    = 0;
    stall_req    = 1'b0;
    rdy_fell     = 1'b0;
    low_run      = 0;
    hold_cnt     = 0;
    stall_cycles = 0;
    load_stimulus();
    i_pad = pixel_t'(f_pad[0]);
    repeat (2) @(posedge PEclk);
    @(negedge PEclk);
    rst_n = 1'b1;
    check_flag("o_pix_rdy", o_pix_rdy, 1'b1);
    check_flag("o_col_vld", o_col_vld, 1'b0);
    check_flag("o_col_last", o_col_last, 1'b0);
    for (int f = 0; f < n_frames; f++) drive_frame(f);
    @(negedge PEclk);
    i_pix_vld = 1'b0;
    waited = 0;
    while (frames_out < n_frames) begin
      waited++;
      if (waited > RUN_WAIT) abort_run("timeout waiting for the last column of the last frame");
      @(negedge PEclk);
    end
    check_flag("o_pix_rdy after last frame", o_pix_rdy, 1'b1);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: pe_feed.f
+incdir+verilog
verilog/pix_pkg.sv
verilog/ctrl_pkg.sv
verilog/frame_bank_if.sv
verilog/pixel_writer.sv
verilog/pingpong_frame_buf.sv
verilog/column_assembler.sv
verilog/credit_tx.sv
verilog/pe_feed_top.sv
sim/tb_pe_feed.sv

// File: Makefile
TOP = tb_pe_feed

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f pe_feed.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: sim/pe_feed_stimulus.txt
# F pad base step stall : one frame, pixel n = (base + step*n) mod 256, pad/base/step in hex
# C frame column element value : expected element of a padded column, value in hex
F 00 10 01 0
F ff 80 03 1
F 5a 00 07 0
F 33 c8 0d 0

C 0 0 0 00
C 0 1 1 10
C 0 1 25 00
C 0 5 3 54
C 0 32 24 0f
C 1 0 12 ff
C 1 2 1 83
C 1 17 10 10
C 1 32 24 7d
C 1 33 5 ff
C 2 1 0 5a
C 2 3 2 ee
C 2 20 13 05
C 2 32 25 5a
C 3 1 1 c8
C 3 9 7 f0
C 3 32 24 bb
C 3 33 25 33
